//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_cop_top
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/cop_ctrl_props.sv
////////////////////////////////////////////////////////////////////////////
// Handshake assertions for the co-processor control block
// Bind of the checker into every cop_ctrl instance
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_ctrl_props (
    input wire                 g_clk,
    input wire                 g_resetn,
    input wire                 cpu_insn_req,
    input wire                 cop_insn_ack,
    input wire                 cop_insn_rsp,
    input wire                 cpu_insn_ack,
    input wire                 valid         // Execute strobe
);

    a_ack_rsp_excl: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp))
        else $error("Request ack and response are high together");

    // Response held until the CPU takes it
    a_rsp_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp)
        else $error("Response dropped before the CPU acknowledged it");

    // EXECUTING is the cycle right after acceptance
    a_valid_exec: assert property (@(posedge g_clk) disable iff (!g_resetn)
        valid |-> $past(cpu_insn_req && cop_insn_ack))
        else $error("Execute strobe outside the cycle after an accepted request");

endmodule

bind cop_ctrl cop_ctrl_props i_cop_ctrl_props (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .cpu_insn_req (cpu_insn_req),
    .cop_insn_ack (cop_insn_ack),
    .cop_insn_rsp (cop_insn_rsp),
    .cpu_insn_ack (cpu_insn_ack),
    .valid        (ex.valid)
);

`default_nettype wire

//--- sim/tb_cop_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the crypto co-processor
// Clock, reset, instruction stimulus and random CPU back-pressure
// Reference model of CPRs and LFSR, response checks and verdict
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module tb_cop_top;
    import cop_pkg::*;

    typedef struct packed {
        logic        wen;          // GPR write expected
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [2:0]  result;
        logic        cpr_we;       // Model update
        logic [3:0]  cpr_addr;
        logic [31:0] cpr_data;
        logic [31:0] lfsr_next;
    } exp_t;

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        cpu_insn_req;
    logic [31:0] cpu_insn_enc;
    logic [31:0] cpu_rs1;
    logic        cpu_insn_ack = 1'b0;  // Driven by back-pressure process
    logic        cop_insn_ack;
    logic        cop_insn_rsp;
    logic        cop_wen;
    logic [4:0]  cop_waddr;
    logic [31:0] cop_wdata;
    result_e     cop_result;

    integer      seed = 32'h51f2_2c0d;
    int          wait_limit = 50;      // Cycles per wait loop
    logic [31:0] cpr_model [16];
    logic [31:0] lfsr_model;
    exp_t        exp_q [$];
    string       name_q [$];
    logic [1:0]  ack_delay = 2'd0;     // Back-pressure of current insn
    logic [1:0]  ack_wait = 2'd0;
    int          cyc = 0;
    int          accept_cyc = 0;
    bit          pending = 1'b0;       // Accepted, not yet retired
    bit          rsp_seen = 1'b0;
    logic        held_wen;
    logic [4:0]  held_waddr;
    logic [31:0] held_wdata;
    logic [2:0]  held_result;

    always #20 g_clk = ~g_clk;         // 40 ns period

    cop_top i_cop_top (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [31:0] make_enc(input logic [2:0] cls, input logic [3:0] sc,
                                              input logic [1:0] pw, input logic [3:0] rs1,
                                              input logic [3:0] rs2, input logic [4:0] dst);
        logic [31:0] e;
        e        = 32'd0;
        e[30:29] = pw;
        e[27:24] = rs2;
        e[23:20] = rs1;
        e[19:15] = dst;                // crd is the low 4 bits
        e[13:10] = sc;
        e[9:7]   = cls;
        e[6:0]   = 7'b0001011;         // custom-0
        return e;
    endfunction

    // Independent lanes, each wrapping at its own width
    function automatic logic [31:0] lane_math(input logic [31:0] a, input logic [31:0] b,
                                               input logic [1:0] pw, input logic sub);
        logic [31:0] r;
        r = 32'd0;
        case (pw)
            2'd0: r = sub ? a - b : a + b;
            2'd1: begin
                for (int i = 0; i < 2; i++) begin
                    r[16*i +: 16] = sub ? a[16*i +: 16] - b[16*i +: 16]
                                        : a[16*i +: 16] + b[16*i +: 16];
                end
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    r[8*i +: 8] = sub ? a[8*i +: 8] - b[8*i +: 8] : a[8*i +: 8] + b[8*i +: 8];
                end
            end
        endcase
        return r;
    endfunction

    function automatic logic [31:0] step_lfsr(input logic [31:0] x);
        return x[0] ? ((x >> 1) ^ RNG_TAPS) : (x >> 1);
    endfunction

    function automatic exp_t ref_exec(input logic [31:0] e, input logic [31:0] rs1);
        exp_t        x;
        logic [3:0]  sc;
        logic [31:0] a;
        logic [31:0] b;
        logic        ok;
        sc = e[13:10];
        a  = cpr_model[e[23:20]];
        b  = cpr_model[e[27:24]];
        ok = e[6:0] == 7'b0001011;
        case (e[9:7])
            3'd0:    ok = ok && sc <= 4'd1;
            3'd1:    ok = ok && sc <= 4'd3;
            3'd2:    ok = ok && sc <= 4'd1 && e[30:29] != 2'd3;
            3'd3:    ok = ok && sc <= 4'd1;
            default: ok = 1'b0;
        endcase
        x           = '0;
        x.waddr     = e[19:15];
        x.cpr_addr  = e[18:15];
        x.lfsr_next = lfsr_model;
        x.result    = ok ? RES_SUCCESS : RES_BAD_INS;
        if (ok) begin
            case (e[9:7])
                3'd0: begin
                    x.wen      = sc == 4'd0;   // MV2GPR
                    x.wdata    = a;
                    x.cpr_we   = sc == 4'd1;   // MV2COP
                    x.cpr_data = rs1;
                end
                3'd1: begin
                    x.cpr_we = 1'b1;
                    case (sc)
                        4'd0:    x.cpr_data = a & b;
                        4'd1:    x.cpr_data = a | b;
                        4'd2:    x.cpr_data = a ^ b;
                        default: x.cpr_data = ~a;
                    endcase
                end
                3'd2: begin
                    x.cpr_we   = 1'b1;
                    x.cpr_data = lane_math(a, b, e[30:29], sc[0]);
                end
                default: begin
                    if (sc == 4'd0) begin
                        x.lfsr_next = (a == 32'd0) ? RNG_RESET : a;
                    end else begin
                        x.cpr_we    = 1'b1;
                        x.cpr_data  = lfsr_model;
                        x.lfsr_next = step_lfsr(lfsr_model);
                    end
                end
            endcase
        end
        return x;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic run_insn(input string name, input logic [31:0] e, input logic [31:0] rs1);
        exp_t        x;
        logic [31:0] r;
        int          t;
        x = ref_exec(e, rs1);
        if (x.cpr_we) begin
            cpr_model[x.cpr_addr] = x.cpr_data;
        end
        lfsr_model = x.lfsr_next;
        exp_q.push_back(x);
        name_q.push_back(name);
        r         = rnd();
        ack_delay = r[1:0];                // 0..3 cycles of back-pressure
        @(posedge g_clk);
        cpu_insn_req <= 1'b1;
        cpu_insn_enc <= e;
        cpu_rs1      <= rs1;
        t = 0;
        do begin
            @(posedge g_clk);
            t++;
            if (t > wait_limit) fail_run("Instruction request was never acknowledged");
        end while (!cop_insn_ack);
        cpu_insn_req <= 1'b0;
        t = 0;
        do begin
            @(posedge g_clk);
            t++;
            if (t > wait_limit) fail_run("Instruction never retired");
        end while (!(cop_insn_rsp && cpu_insn_ack));
    endtask

    task automatic readback(input logic [3:0] idx);
        logic [31:0] r;
        r = rnd();
        run_insn("mv2gpr", make_enc(3'd0, SC_MV2GPR, 2'd0, idx, 4'd0, r[4:0]), 32'd0);
    endtask

    task automatic readback_all();
        for (int i = 0; i < 16; i++) begin
            readback(4'(i));
        end
    endtask

    // CPU side retire acknowledge
    always @(posedge g_clk) begin
        if (!g_resetn || !cop_insn_rsp || cpu_insn_ack) begin
            cpu_insn_ack <= 1'b0;
            ack_wait     <= 2'd0;
        end else if (ack_wait == ack_delay) begin
            cpu_insn_ack <= 1'b1;
        end else begin
            ack_wait <= ack_wait + 2'd1;
        end
    end

    // Compare process, pre-edge values only
    always @(posedge g_clk) begin
        exp_t  x;
        string nm;
        cyc++;
        if (!g_resetn && cyc > 1) begin
            check_value("reset_ack", 32'd0, {31'd0, cop_insn_ack});
            check_value("reset_rsp", 32'd0, {31'd0, cop_insn_rsp});
            check_value("reset_wen", 32'd0, {31'd0, cop_wen});
            check_value("reset_result", {29'd0, RES_SUCCESS}, {29'd0, cop_result});
        end else if (g_resetn) begin
            if (cpu_insn_req && cop_insn_ack) begin
                pending    = 1'b1;
                accept_cyc = cyc;
            end
            if (cop_insn_rsp && !rsp_seen) begin
                if (!pending) fail_run("Response raised without an accepted request");
                check_value("rsp_latency", 32'(accept_cyc + 2), 32'(cyc)); // Rose at A+1
                rsp_seen    = 1'b1;
                held_wen    = cop_wen;
                held_waddr  = cop_waddr;
                held_wdata  = cop_wdata;
                held_result = cop_result;
            end else if (cop_insn_rsp) begin
                check_value("hold_wen", {31'd0, held_wen}, {31'd0, cop_wen});
                check_value("hold_waddr", {27'd0, held_waddr}, {27'd0, cop_waddr});
                check_value("hold_wdata", held_wdata, cop_wdata);
                check_value("hold_result", {29'd0, held_result}, {29'd0, cop_result});
            end
            if (cop_insn_rsp && cpu_insn_ack) begin
                if (exp_q.size() == 0) fail_run("Response with no expected result");
                x  = exp_q.pop_front();
                nm = name_q.pop_front();
                check_value({nm, " result"}, {29'd0, x.result}, {29'd0, cop_result});
                check_value({nm, " wen"}, {31'd0, x.wen}, {31'd0, cop_wen});
                if (x.wen) begin
                    check_value({nm, " waddr"}, {27'd0, x.waddr}, {27'd0, cop_waddr});
                    check_value({nm, " wdata"}, x.wdata, cop_wdata);
                end
                pending  = 1'b0;
                rsp_seen = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] v;
        int          t;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = 32'd0;
        cpu_rs1      = 32'd0;
        lfsr_model   = RNG_RESET;
        for (int i = 0; i < 16; i++) begin
            cpr_model[i] = 32'd0;
        end
        repeat (10) @(posedge g_clk);
        g_resetn <= 1'b1;
        t = 0;
        do begin                           // IDLE cycle, then ack
            @(posedge g_clk);
            t++;
            if (t > wait_limit) fail_run("Request ack never rose after reset");
        end while (!cop_insn_ack);
        check_value("ack_after_reset", 32'd2, 32'(t));

        for (int i = 0; i < 16; i++) begin
            run_insn("mv2cop", make_enc(3'd0, SC_MV2COP, 2'd0, 4'd0, 4'd0, 5'(i)), rnd());
        end
        readback_all();

        for (int n = 0; n < 12; n++) begin // Each op three times
            v = rnd();
            run_insn("bitwise", make_enc(3'd1, 4'(n % 4), 2'd0, v[3:0], v[7:4],
                                         {1'b0, v[11:8]}), 32'd0);
            readback(v[11:8]);
        end

        for (int p = 0; p < 3; p++) begin
            for (int s = 0; s < 2; s++) begin
                run_insn("mv2cop", make_enc(3'd0, SC_MV2COP, 2'd0, 4'd0, 4'd0, 5'd14),
                         32'hffff_ffff);
                run_insn("packed_ones", make_enc(3'd2, 4'(s), 2'(p), 4'd14, 4'd14, 5'd15),
                         32'd0);
                readback(4'd15);
                v = rnd();
                run_insn("packed_rand", make_enc(3'd2, 4'(s), 2'(p), v[3:0], v[7:4],
                                                 {2'b0, v[10:8]}), 32'd0);
                readback({1'b0, v[10:8]});
            end
        end

        for (int k = 0; k < 2; k++) begin  // Random seed, then zero
            v = (k == 0) ? rnd() : 32'd0;
            run_insn("mv2cop", make_enc(3'd0, SC_MV2COP, 2'd0, 4'd0, 4'd0, 5'd3), v);
            run_insn("seed", make_enc(3'd3, SC_SEED, 2'd0, 4'd3, 4'd0, 5'd0), 32'd0);
            for (int n = 0; n < 5; n++) begin
                run_insn("sample", make_enc(3'd3, SC_SAMPLE, 2'd0, 4'd0, 4'd0, 5'd9), 32'd0);
                readback(4'd9);
            end
        end

        v      = make_enc(3'd0, SC_MV2COP, 2'd0, 4'd1, 4'd2, 5'd4);
        v[6:0] = 7'b0101011;               // Not custom-0
        run_insn("bad_major", v, rnd());
        run_insn("bad_class", make_enc(3'd5, 4'd0, 2'd0, 4'd1, 4'd2, 5'd5), rnd());
        run_insn("bad_sclass", make_enc(3'd1, 4'd7, 2'd0, 4'd1, 4'd2, 5'd6), rnd());
        run_insn("bad_pw", make_enc(3'd2, SC_ADD, 2'd3, 4'd1, 4'd2, 5'd7), rnd());
        readback_all();                    // CPRs untouched

        @(posedge g_clk);
        if (exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run("Responses still outstanding at the end of the test");
        end
    end

endmodule

`default_nettype wire

//--- src.f
src/cop_pkg.sv
src/cop_exec_if.sv
src/cop_decode.sv
src/cop_ctrl.sv
src/cop_cprs.sv
src/cop_palu.sv
src/cop_rng.sv
src/cop_top.sv
sim/cop_ctrl_props.sv
sim/tb_cop_top.sv

//--- src/cop_cprs.sv
////////////////////////////////////////////////////////////////////////////
// Co-processor register file
// 16 x 32-bit CPRs, two asynchronous read ports, one merged write port
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_cprs (
    input  wire                       g_clk,
    input  wire                       g_resetn,
    cop_exec_if.regs                  ex,
    input  wire                       palu_wen,    // From packed ALU
    input  wire  [cop_pkg::XLEN-1:0]  palu_wdata,
    input  wire                       rng_wen,     // From random source
    input  wire  [cop_pkg::XLEN-1:0]  rng_wdata,
    output logic [cop_pkg::XLEN-1:0]  crs1_rdata,
    output logic [cop_pkg::XLEN-1:0]  crs2_rdata
);
    import cop_pkg::*;

    logic [XLEN-1:0] cprs [2**CPR_AW];
    logic            crd_wen;
    logic [XLEN-1:0] crd_wdata;

    // Units never enable together
    assign crd_wen   = ex.valid && (palu_wen || rng_wen);
    assign crd_wdata = palu_wen ? palu_wdata : rng_wdata;

    assign crs1_rdata = cprs[ex.crs1];
    assign crs2_rdata = cprs[ex.crs2];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 2**CPR_AW; i++) begin
                cprs[i] <= '0;
            end
        end else if (crd_wen) begin
            cprs[ex.crd] <= crd_wdata;               // Whole-word write
        end
    end

endmodule

`default_nettype wire

//--- src/cop_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Co-processor control
// CPU handshake FSM, instruction and rs1 capture
// Execute strobe and GPR writeback / result registers
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_ctrl (
    input  wire                         g_clk,
    input  wire                         g_resetn,
    input  wire                         cpu_insn_req,  // Instruction request
    output logic                        cop_insn_ack,  // Request acknowledge
    input  wire  [cop_pkg::XLEN-1:0]    cpu_insn_enc,
    input  wire  [cop_pkg::XLEN-1:0]    cpu_rs1,
    output logic                        cop_insn_rsp,  // Instruction finished
    input  wire                         cpu_insn_ack,  // Finish acknowledge
    cop_exec_if.ctrl                    ex,
    input  wire  [cop_pkg::XLEN-1:0]    crs1_rdata,    // Source for MV2GPR
    output logic                        cop_wen,
    output logic [cop_pkg::GPR_AW-1:0]  cop_waddr,
    output logic [cop_pkg::XLEN-1:0]    cop_wdata,
    output cop_pkg::result_e            cop_result,
    output logic [cop_pkg::XLEN-1:0]    insn_enc       // To decoder
);
    import cop_pkg::*;

    fsm_e cop_fsm;
    fsm_e n_cop_fsm;
    logic n_cop_insn_ack;
    logic n_cop_insn_rsp;
    logic insn_accept;
    logic insn_retired;
    logic executing;

    assign insn_accept  = cpu_insn_req && cop_insn_ack;
    assign insn_retired = cop_insn_rsp && cpu_insn_ack;
    assign executing    = cop_fsm == FSM_EXECUTING;

    always_comb begin
        n_cop_fsm      = cop_fsm;
        n_cop_insn_ack = 1'b0;
        n_cop_insn_rsp = 1'b0;
        case (cop_fsm)
            FSM_IDLE: begin
                n_cop_fsm      = FSM_WAITING;
                n_cop_insn_ack = 1'b1;
            end
            FSM_WAITING: begin
                if (insn_accept) begin
                    n_cop_fsm      = FSM_EXECUTING;  // Ack drops at acceptance
                end else begin
                    n_cop_insn_ack = 1'b1;
                end
            end
            FSM_EXECUTING: begin
                n_cop_fsm      = FSM_FINISHED;       // Single-cycle execute
                n_cop_insn_rsp = 1'b1;
            end
            default: begin
                if (insn_retired) begin
                    n_cop_fsm      = FSM_WAITING;
                    n_cop_insn_ack = 1'b1;           // Ready on retire edge
                end else begin
                    n_cop_insn_rsp = 1'b1;           // Hold under back-pressure
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_fsm      <= FSM_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
        end else begin
            cop_fsm      <= n_cop_fsm;
            cop_insn_ack <= n_cop_insn_ack;
            cop_insn_rsp <= n_cop_insn_rsp;
        end
    end

    // Encoding and rs1 held for the whole instruction
    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            insn_enc   <= cpu_insn_enc;
            ex.gpr_rs1 <= cpu_rs1;
        end
    end

    assign ex.valid = executing && !ex.illegal;  // No strobe for bad encodings

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_wen    <= 1'b0;
            cop_result <= RES_SUCCESS;
        end else if (executing) begin
            cop_wen    <= !ex.illegal && ex.iclass == ICLASS_MOVE &&
                          ex.sclass == SC_MV2GPR;
            cop_result <= ex.illegal ? RES_BAD_INS : RES_SUCCESS;
        end
    end

    always_ff @(posedge g_clk) begin
        if (executing) begin
            cop_waddr <= ex.rd;
            cop_wdata <= crs1_rdata;                 // Only meaningful for MV2GPR
        end
    end

endmodule

`default_nettype wire

//--- src/cop_decode.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decoder
// Field slicing and legality check of the captured encoding
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_decode (
    input  wire  [cop_pkg::XLEN-1:0] insn_enc,   // Captured instruction
    cop_exec_if.decode               ex          // Decoded fields
);
    import cop_pkg::*;

    logic [6:0] major;                           // Major opcode
    logic [2:0] class_raw;
    logic [3:0] sclass_raw;
    logic       bad_major;
    logic       bad_sclass;                      // Class or subclass out of range
    logic       bad_pw;

    assign major      = insn_enc[6:0];
    assign class_raw  = insn_enc[9:7];
    assign sclass_raw = insn_enc[13:10];

    assign ex.iclass = iclass_e'(class_raw);
    assign ex.sclass = sclass_e'(sclass_raw);
    assign ex.pw     = pw_e'(insn_enc[30:29]);
    assign ex.crs2   = insn_enc[27:24];
    assign ex.crs1   = insn_enc[23:20];
    assign ex.crd    = insn_enc[18:15];
    assign ex.rd     = insn_enc[19:15];          // Overlaps crd, one bit wider

    assign bad_major = major != COP_MAJOR;

    // Subclass range depends on class
    always_comb begin
        case (class_raw)
            3'd0:    bad_sclass = sclass_raw > SC_MV2COP;
            3'd1:    bad_sclass = sclass_raw > SC_NOT;
            3'd2:    bad_sclass = sclass_raw > SC_SUB;
            3'd3:    bad_sclass = sclass_raw > SC_SAMPLE;
            default: bad_sclass = 1'b1;          // Class 4..7 unused
        endcase
    end

    // Width 3 only matters for packed arithmetic
    assign bad_pw = (class_raw == 3'd2) && (&insn_enc[30:29]);

    assign ex.illegal = bad_major || bad_sclass || bad_pw;

endmodule

`default_nettype wire

//--- src/cop_exec_if.sv
////////////////////////////////////////////////////////////////////////////
// Execute bundle between control, decoder, CPR file and units
// Modports for decode, ctrl, unit and regs
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

interface cop_exec_if;
    import cop_pkg::*;

    logic              valid;         // Execute strobe, one cycle
    logic              illegal;       // Decode rejected the encoding
    iclass_e           iclass;
    sclass_e           sclass;
    pw_e               pw;            // Pack width
    logic [CPR_AW-1:0] crs1;
    logic [CPR_AW-1:0] crs2;
    logic [CPR_AW-1:0] crd;
    logic [GPR_AW-1:0] rd;            // GPR destination
    logic [XLEN-1:0]   gpr_rs1;       // Captured CPU rs1

    modport decode (
        output illegal, iclass, sclass, pw, crs1, crs2, crd, rd
    );

    modport ctrl (
        output valid, gpr_rs1,
        input  illegal, iclass, sclass, rd
    );

    modport unit (
        input valid, illegal, iclass, sclass, pw, crs1, crs2, crd, rd, gpr_rs1
    );

    modport regs (
        input valid, crs1, crs2, crd
    );

endinterface

`default_nettype wire

//--- src/cop_palu.sv
////////////////////////////////////////////////////////////////////////////
// Packed ALU
// GPR-to-CPR move, bitwise logic, lane-wise add/sub at 32, 16 and 8 bits
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_palu (
    cop_exec_if.unit                  ex,
    input  wire  [cop_pkg::XLEN-1:0]  crs1_rdata,
    input  wire  [cop_pkg::XLEN-1:0]  crs2_rdata,
    output logic                      palu_wen,
    output logic [cop_pkg::XLEN-1:0]  palu_wdata
);
    import cop_pkg::*;

    logic            is_sub;
    logic [XLEN-1:0] add_b;      // Second operand, inverted for SUB
    logic            cin;        // Running byte carry
    logic [8:0]      byte_sum;
    logic [XLEN-1:0] pack_res;
    logic [XLEN-1:0] bit_res;

    assign is_sub = ex.sclass == SC_SUB;
    assign add_b  = is_sub ? ~crs2_rdata : crs2_rdata;

    // Byte-sliced adder, carry chain cut at each lane start
    // SUB gets a + ~b + 1 per lane via carry-in
    always_comb begin
        cin      = is_sub;
        pack_res = '0;
        byte_sum = '0;
        for (int i = 0; i < XLEN/8; i++) begin
            if ((ex.pw == PW_8) || (ex.pw == PW_16 && i % 2 == 0)) begin
                cin = is_sub;                          // New lane
            end
            byte_sum = {1'b0, crs1_rdata[8*i +: 8]} + {1'b0, add_b[8*i +: 8]} +
                       {8'd0, cin};
            pack_res[8*i +: 8] = byte_sum[7:0];
            cin = byte_sum[8];
        end
    end

    always_comb begin
        case (ex.sclass)
            SC_AND:  bit_res = crs1_rdata & crs2_rdata;
            SC_OR:   bit_res = crs1_rdata | crs2_rdata;
            SC_XOR:  bit_res = crs1_rdata ^ crs2_rdata;
            default: bit_res = ~crs1_rdata;           // SC_NOT
        endcase
    end

    always_comb begin
        case (ex.iclass)
            ICLASS_MOVE:    palu_wdata = ex.gpr_rs1;  // MV2COP
            ICLASS_BITWISE: palu_wdata = bit_res;
            default:        palu_wdata = pack_res;
        endcase
    end

    // MV2GPR goes out through ctrl, not the CPR file
    assign palu_wen = ex.valid &&
                      ((ex.iclass == ICLASS_MOVE && ex.sclass == SC_MV2COP) ||
                       ex.iclass == ICLASS_BITWISE ||
                       ex.iclass == ICLASS_PACKED);

endmodule

`default_nettype wire

//--- src/cop_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions of the crypto co-processor
// Data and register address widths, custom-0 major opcode
// Class, subclass, pack width, result and FSM state types
// LFSR reset value and tap mask
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cop_pkg;

    localparam int XLEN   = 32;               // Data width
    localparam int CPR_AW = 4;                // 16 CPRs
    localparam int GPR_AW = 5;                // 32 GPRs

    localparam logic [6:0] COP_MAJOR = 7'b0001011; // custom-0

    // Instruction class, bits 9..7
    typedef enum logic [2:0] {
        ICLASS_MOVE    = 3'd0,                // GPR <-> CPR moves
        ICLASS_BITWISE = 3'd1,                // AND/OR/XOR/NOT
        ICLASS_PACKED  = 3'd2,                // Lane-wise add/sub
        ICLASS_RANDOM  = 3'd3                 // LFSR seed/sample
    } iclass_e;

    // Subclass codes overlap between classes, so plain constants
    typedef logic [3:0] sclass_e;
    localparam sclass_e SC_MV2GPR = 4'd0;     // CPR to GPR
    localparam sclass_e SC_MV2COP = 4'd1;     // GPR to CPR
    localparam sclass_e SC_AND    = 4'd0;
    localparam sclass_e SC_OR     = 4'd1;
    localparam sclass_e SC_XOR    = 4'd2;
    localparam sclass_e SC_NOT    = 4'd3;     // Unary, crs1 only
    localparam sclass_e SC_ADD    = 4'd0;
    localparam sclass_e SC_SUB    = 4'd1;
    localparam sclass_e SC_SEED   = 4'd0;     // Load LFSR from crs1
    localparam sclass_e SC_SAMPLE = 4'd1;     // Read and step LFSR

    typedef enum logic [1:0] {
        PW_32 = 2'd0,
        PW_16 = 2'd1,
        PW_8  = 2'd2                          // 3 is illegal
    } pw_e;

    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0,
        RES_BAD_INS = 3'd1                    // Illegal instruction
    } result_e;

    typedef enum logic [1:0] {
        FSM_IDLE      = 2'd0,                 // One cycle after reset
        FSM_WAITING   = 2'd1,                 // Ready for a request
        FSM_EXECUTING = 2'd2,                 // Units active
        FSM_FINISHED  = 2'd3                  // Response held
    } fsm_e;

    localparam logic [XLEN-1:0] RNG_RESET = 32'h0000_0001; // Never all zero
    localparam logic [XLEN-1:0] RNG_TAPS  = 32'h8020_0003; // Galois taps

endpackage

`default_nettype wire

//--- src/cop_rng.sv
////////////////////////////////////////////////////////////////////////////
// Random source
// 32-bit Galois LFSR with seed and sample operations
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_rng (
    input  wire                       g_clk,
    input  wire                       g_resetn,
    cop_exec_if.unit                  ex,
    input  wire  [cop_pkg::XLEN-1:0]  crs1_rdata,  // Seed value
    output logic                      rng_wen,
    output logic [cop_pkg::XLEN-1:0]  rng_wdata
);
    import cop_pkg::*;

    logic [XLEN-1:0] lfsr;
    logic [XLEN-1:0] lfsr_step;
    logic            rng_op;
    logic            do_seed;

    assign rng_op  = ex.valid && ex.iclass == ICLASS_RANDOM;
    assign do_seed = rng_op && ex.sclass == SC_SEED;

    // Shift right, fold taps in when a one drops out
    assign lfsr_step = (lfsr >> 1) ^ ({XLEN{lfsr[0]}} & RNG_TAPS);

    assign rng_wen   = rng_op && ex.sclass == SC_SAMPLE;
    assign rng_wdata = lfsr;                         // Pre-step value

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr <= RNG_RESET;
        end else if (do_seed) begin
            lfsr <= (crs1_rdata == '0) ? RNG_RESET : crs1_rdata; // Zero would lock up
        end else if (rng_wen) begin
            lfsr <= lfsr_step;
        end
    end

endmodule

`default_nettype wire

//--- src/cop_top.sv
////////////////////////////////////////////////////////////////////////////
// Crypto co-processor top level
// Control, decoder, CPR file, packed ALU and random source
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module cop_top (
    input  wire                         g_clk,         // Global clock
    input  wire                         g_resetn,      // Sync, active low
    input  wire                         cpu_insn_req,
    input  wire  [cop_pkg::XLEN-1:0]    cpu_insn_enc,
    input  wire  [cop_pkg::XLEN-1:0]    cpu_rs1,
    output logic                        cop_insn_ack,
    output logic                        cop_insn_rsp,
    input  wire                         cpu_insn_ack,
    output logic                        cop_wen,       // GPR write enable
    output logic [cop_pkg::GPR_AW-1:0]  cop_waddr,
    output logic [cop_pkg::XLEN-1:0]    cop_wdata,
    output cop_pkg::result_e            cop_result
);
    import cop_pkg::*;

    logic [XLEN-1:0] insn_enc;       // Captured encoding
    logic [XLEN-1:0] crs1_rdata;
    logic [XLEN-1:0] crs2_rdata;
    logic            palu_wen;
    logic [XLEN-1:0] palu_wdata;
    logic            rng_wen;
    logic [XLEN-1:0] rng_wdata;

    cop_exec_if i_exec_if ();

    cop_ctrl i_cop_ctrl (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cop_insn_rsp (cop_insn_rsp),
        .cpu_insn_ack (cpu_insn_ack),
        .ex           (i_exec_if),
        .crs1_rdata   (crs1_rdata),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result),
        .insn_enc     (insn_enc)
    );

    cop_decode i_cop_decode (
        .insn_enc (insn_enc),
        .ex       (i_exec_if)
    );

    cop_cprs i_cop_cprs (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .ex         (i_exec_if),
        .palu_wen   (palu_wen),
        .palu_wdata (palu_wdata),
        .rng_wen    (rng_wen),
        .rng_wdata  (rng_wdata),
        .crs1_rdata (crs1_rdata),
        .crs2_rdata (crs2_rdata)
    );

    cop_palu i_cop_palu (
        .ex         (i_exec_if),
        .crs1_rdata (crs1_rdata),
        .crs2_rdata (crs2_rdata),
        .palu_wen   (palu_wen),
        .palu_wdata (palu_wdata)
    );

    cop_rng i_cop_rng (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .ex         (i_exec_if),
        .crs1_rdata (crs1_rdata),
        .rng_wen    (rng_wen),
        .rng_wdata  (rng_wdata)
    );

endmodule

`default_nettype wire
